// ==== hdl/bus_types_pkg.sv ====
package bus_types_pkg;

  // byte address bits 23..1, bit 0 is replaced by the two byte strobes
  localparam int ADDR_MSB = 23;
  localparam int DATA_W   = 16;

  // word address as seen on both sides of the bridge
  typedef logic [ADDR_MSB:1] addr_t;

  // one 16-bit bus word
  typedef logic [DATA_W-1:0] data_t;

  // [1] upper byte, [0] lower byte, active high inside the design
  typedef logic [1:0] byte_sel_t;

endpackage

// ==== hdl/chip_timing_pkg.sv ====
package chip_timing_pkg;

  localparam int ECLK_PHASE_W = 4;

  // defaults for the top level parameters
  localparam int ECLK_PHASES_DEF = 10;
  localparam int CCK_HALF_DEF    = 2;  // clk cycles per cck half period

  typedef logic [ECLK_PHASE_W-1:0] eclk_phase_t;

  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    WAIT_SLOT = 3'd1,  // waiting for a free chip bus slot
    ACK       = 3'd2,
    STROBE    = 3'd3,
    RELEASE   = 3'd4
  } ctrl_state_t;

endpackage

// ==== hdl/bus_clock_gen.sv ====
`timescale 1ns/100ps

module bus_clock_gen #(
  parameter int ECLK_PHASES = chip_timing_pkg::ECLK_PHASES_DEF,
  parameter int CCK_HALF    = chip_timing_pkg::CCK_HALF_DEF
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         vpa,
  output logic                         cck,
  output chip_timing_pkg::eclk_phase_t eclk_phase,
  output logic                         vma
);

  import chip_timing_pkg::*;

  localparam int               CNT_W      = (CCK_HALF > 1) ? $clog2(CCK_HALF) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST   = CNT_W'(CCK_HALF - 1);
  localparam eclk_phase_t      PHASE_LAST = eclk_phase_t'(ECLK_PHASES - 1);
  localparam eclk_phase_t      VMA_OPEN   = eclk_phase_t'(3);

  logic [CNT_W-1:0] half_cnt;
  logic             cck_rise;
  logic             vpa_q;

  // cck about to go high on this edge
  assign cck_rise = (half_cnt == CNT_LAST) && !cck;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      half_cnt <= '0;
      cck      <= 1'b0;
    end else if (half_cnt == CNT_LAST) begin
      half_cnt <= '0;
      cck      <= !cck;
    end else begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  // E-clock phase, one step per cck period
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      eclk_phase <= '0;
    end else if (cck_rise) begin
      if (eclk_phase == PHASE_LAST)
        eclk_phase <= '0;
      else
        eclk_phase <= eclk_phase + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      vpa_q <= 1'b0;
    else
      vpa_q <= vpa;
  end

  // 6800 style valid memory address window
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vma <= 1'b0;
    end else if (eclk_phase == PHASE_LAST) begin
      vma <= 1'b0;  // end of E period closes the window
    end else if (eclk_phase == VMA_OPEN && vpa_q) begin
      vma <= 1'b1;
    end
  end

endmodule

// ==== hdl/bus_master_mux.sv ====
`timescale 1ns/100ps

module bus_master_mux (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     sel_host,
  // cpu side, active low strobes
  input  logic                     as_n,
  input  logic                     uds_n,
  input  logic                     lds_n,
  input  logic                     r_w,
  input  bus_types_pkg::addr_t     address,
  input  bus_types_pkg::data_t     cpu_wdata,
  // host side, active high strobes
  input  logic                     host_cs,
  input  logic                     host_we,
  input  bus_types_pkg::byte_sel_t host_bs,
  input  bus_types_pkg::addr_t     host_adr,
  input  bus_types_pkg::data_t     host_wdat,
  output logic                     req_as,
  output logic                     req_rw,
  output bus_types_pkg::byte_sel_t req_bs,
  output bus_types_pkg::addr_t     address_out,
  output bus_types_pkg::data_t     data_out
);

  import bus_types_pkg::*;

  logic      cur_as;
  logic      cur_rw;
  byte_sel_t cur_bs;
  byte_sel_t cpu_bs;

  assign cpu_bs = {!uds_n, !lds_n};

  // one request form for both masters, high = active, rw high = read
  always_comb begin
    if (sel_host) begin
      cur_as = host_cs;
      cur_rw = !host_we;
      cur_bs = host_bs;
    end else begin
      cur_as = !as_n;
      cur_rw = r_w;
      cur_bs = cpu_bs;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_as <= 1'b0;
      req_rw <= 1'b1;
      req_bs <= '0;
    end else begin
      req_as <= cur_as;
      req_rw <= cur_rw;
      req_bs <= cur_bs;
    end
  end

  assign address_out = sel_host ? host_adr : address;
  assign data_out    = sel_host ? host_wdat : cpu_wdata;

endmodule

// ==== hdl/read_capture.sv ====
`timescale 1ns/100ps

module read_capture (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cap_en,
  input  bus_types_pkg::data_t data_in,
  output bus_types_pkg::data_t rdata
);

  import bus_types_pkg::*;

  data_t hold_q;

  // chip bus moves on after the strobe, so keep the word here
  always_ff @(posedge clk) begin
    if (!rst_n)
      hold_q <= '0;
    else if (cap_en)
      hold_q <= data_in;  // last cycle of the read strobe
  end

  assign rdata = hold_q;

endmodule

// ==== hdl/bridge_ctrl.sv ====
`timescale 1ns/100ps

module bridge_ctrl #(
  parameter int ECLK_PHASES = chip_timing_pkg::ECLK_PHASES_DEF,
  parameter int CCK_HALF    = chip_timing_pkg::CCK_HALF_DEF
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         cpu_halt,
  input  logic                         as_n,
  input  logic                         vpa,
  input  logic                         req_as,
  input  logic                         req_rw,
  input  bus_types_pkg::byte_sel_t     req_bs,
  input  logic                         cck,
  input  chip_timing_pkg::eclk_phase_t eclk_phase,
  input  logic                         vma,
  input  logic                         dbr,
  input  logic                         nrdy,
  output logic                         sel_host,
  output logic                         halted,
  output logic                         dtack_n,
  output logic                         host_ack,
  output logic                         rd,
  output logic                         hwr,
  output logic                         lwr,
  output logic                         cap_en
);

  import bus_types_pkg::*;
  import chip_timing_pkg::*;

  localparam eclk_phase_t      ACK_PHASE = eclk_phase_t'(ECLK_PHASES - 2);
  localparam int               CNT_W     = (CCK_HALF > 1) ? $clog2(CCK_HALF) : 1;
  localparam logic [CNT_W-1:0] STB_LAST  = CNT_W'(CCK_HALF - 1);

  ctrl_state_t      state;
  logic [CNT_W-1:0] stb_cnt;
  logic             own_chg;   // request register still holds the old owner
  logic             req_gone;  // master let go before RELEASE
  logic             vpa_cycle;
  logic             slot_ok;
  logic             strobe_on;
  byte_sel_t        wr_lanes;

  // peripheral timing only applies to cpu cycles
  assign vpa_cycle = vpa && !halted;

  always_comb begin
    if (vpa_cycle)
      slot_ok = cck && vma && (eclk_phase == ACK_PHASE) && !nrdy;
    else
      slot_ok = cck && !dbr && !nrdy;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= IDLE;
      stb_cnt  <= '0;
      halted   <= 1'b0;
      own_chg  <= 1'b0;
      req_gone <= 1'b0;
      dtack_n  <= 1'b1;
      host_ack <= 1'b0;
    end else begin
      host_ack <= 1'b0;
      own_chg  <= 1'b0;
      case (state)
        IDLE: begin
          req_gone <= 1'b0;
          if (as_n && (halted != cpu_halt)) begin
            halted  <= cpu_halt;  // hand over only between cycles
            own_chg <= 1'b1;
          end else if (req_as && !own_chg) begin
            state <= WAIT_SLOT;
          end
        end
        WAIT_SLOT: begin
          // dbr and nrdy simply keep us here
          if (slot_ok) begin
            state <= ACK;
            if (halted)
              host_ack <= 1'b1;
            else
              dtack_n <= 1'b0;
          end
        end
        ACK: begin
          if (!cck) begin
            state   <= STROBE;
            stb_cnt <= '0;
          end
        end
        STROBE: begin
          if (stb_cnt == STB_LAST)
            state <= RELEASE;
          else
            stb_cnt <= stb_cnt + 1'b1;
        end
        RELEASE: begin
          if (!req_as || req_gone)
            state <= IDLE;
        end
        default: state <= IDLE;
      endcase

      // master has seen the acknowledge and dropped its strobe
      if ((state == ACK || state == STROBE || state == RELEASE) && !req_as) begin
        dtack_n  <= 1'b1;
        req_gone <= 1'b1;
      end
    end
  end

  assign strobe_on = (state == STROBE);
  assign wr_lanes  = req_rw ? '0 : req_bs;

  assign rd     = strobe_on && req_rw;
  assign hwr    = strobe_on && wr_lanes[1];
  assign lwr    = strobe_on && wr_lanes[0];
  assign cap_en = rd && (stb_cnt == STB_LAST);  // close of read strobe

  assign sel_host = halted;

endmodule

// ==== hdl/chip_bus_bridge.sv ====
`timescale 1ns/100ps

module chip_bus_bridge #(
  parameter int ECLK_PHASES = chip_timing_pkg::ECLK_PHASES_DEF,
  parameter int CCK_HALF    = chip_timing_pkg::CCK_HALF_DEF
) (
  input  logic                     clk,
  input  logic                     rst_n,
  // 68000 style cpu bus
  input  logic                     as_n,
  input  logic                     uds_n,
  input  logic                     lds_n,
  input  logic                     r_w,
  input  bus_types_pkg::addr_t     address,
  input  bus_types_pkg::data_t     cpu_wdata,
  input  logic                     vpa,
  output logic                     dtack_n,
  output bus_types_pkg::data_t     cpu_rdata,
  // host port, served while halted
  input  logic                     cpu_halt,
  output logic                     halted,
  input  logic                     host_cs,
  input  logic                     host_we,
  input  bus_types_pkg::byte_sel_t host_bs,
  input  bus_types_pkg::addr_t     host_adr,
  input  bus_types_pkg::data_t     host_wdat,
  output logic                     host_ack,
  output bus_types_pkg::data_t     host_rdat,
  // chip bus
  output bus_types_pkg::addr_t     address_out,
  output bus_types_pkg::data_t     data_out,
  output logic                     rd,
  output logic                     hwr,
  output logic                     lwr,
  input  bus_types_pkg::data_t     data_in,
  input  logic                     dbr,
  input  logic                     nrdy
);

  import bus_types_pkg::*;
  import chip_timing_pkg::*;

  logic        cck;
  logic        vma;
  eclk_phase_t eclk_phase;
  logic        sel_host;
  logic        cap_en;
  logic        req_as;
  logic        req_rw;
  byte_sel_t   req_bs;
  data_t       rdata;

  bus_clock_gen #(
    .ECLK_PHASES (ECLK_PHASES),
    .CCK_HALF    (CCK_HALF)
  ) i_clock_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .vpa        (vpa),
    .cck        (cck),
    .eclk_phase (eclk_phase),
    .vma        (vma)
  );

  bus_master_mux i_mux (
    .clk         (clk),
    .rst_n       (rst_n),
    .sel_host    (sel_host),
    .as_n        (as_n),
    .uds_n       (uds_n),
    .lds_n       (lds_n),
    .r_w         (r_w),
    .address     (address),
    .cpu_wdata   (cpu_wdata),
    .host_cs     (host_cs),
    .host_we     (host_we),
    .host_bs     (host_bs),
    .host_adr    (host_adr),
    .host_wdat   (host_wdat),
    .req_as      (req_as),
    .req_rw      (req_rw),
    .req_bs      (req_bs),
    .address_out (address_out),
    .data_out    (data_out)
  );

  read_capture i_capture (
    .clk     (clk),
    .rst_n   (rst_n),
    .cap_en  (cap_en),
    .data_in (data_in),
    .rdata   (rdata)
  );

  bridge_ctrl #(
    .ECLK_PHASES (ECLK_PHASES),
    .CCK_HALF    (CCK_HALF)
  ) i_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .cpu_halt   (cpu_halt),
    .as_n       (as_n),
    .vpa        (vpa),
    .req_as     (req_as),
    .req_rw     (req_rw),
    .req_bs     (req_bs),
    .cck        (cck),
    .eclk_phase (eclk_phase),
    .vma        (vma),
    .dbr        (dbr),
    .nrdy       (nrdy),
    .sel_host   (sel_host),
    .halted     (halted),
    .dtack_n    (dtack_n),
    .host_ack   (host_ack),
    .rd         (rd),
    .hwr        (hwr),
    .lwr        (lwr),
    .cap_en     (cap_en)
  );

  // one holding register serves both masters
  assign cpu_rdata = rdata;
  assign host_rdat = rdata;

endmodule

// ==== sim/bridge_assert.sv ====
`timescale 1ns/100ps

module bridge_assert (
  input logic                         clk,
  input logic                         rst_n,
  input chip_timing_pkg::ctrl_state_t state,
  input logic                         sel_host,
  input logic                         dtack_n,
  input logic                         host_ack,
  input logic                         rd,
  input logic                         hwr,
  input logic                         lwr
);

  import chip_timing_pkg::*;

  a_rd_vs_wr: assert property (@(posedge clk) disable iff (!rst_n)
    rd |-> !(hwr || lwr))
    else $error("rd overlaps a write strobe");

  a_strobe_state: assert property (@(posedge clk) disable iff (!rst_n)
    (rd || hwr || lwr) |-> (state == STROBE))
    else $error("strobe outside STROBE state");

  a_one_ack: assert property (@(posedge clk) disable iff (!rst_n)
    !(!dtack_n && host_ack))
    else $error("dtack_n and host_ack active together");

  // ownership moves only between bus cycles
  a_owner_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (sel_host != $past(sel_host)) |-> ($past(state) == IDLE))
    else $error("sel_host changed outside IDLE");

endmodule

bind bridge_ctrl bridge_assert i_assert (
  .clk      (clk),
  .rst_n    (rst_n),
  .state    (state),
  .sel_host (sel_host),
  .dtack_n  (dtack_n),
  .host_ack (host_ack),
  .rd       (rd),
  .hwr      (hwr),
  .lwr      (lwr)
);

// ==== sim/tb_chip_bus_bridge.sv ====
`timescale 1ns/100ps

module tb_chip_bus_bridge;

  import bus_types_pkg::*;
  import chip_timing_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int ACK_LIMIT    = 200;
  localparam int NUM_TRANS    = 300;
  localparam int CYCLE_LIMIT  = NUM_TRANS * ACK_LIMIT + RESET_CYCLES;
  localparam int ACK_PHASE    = ECLK_PHASES_DEF - 2;
  localparam logic [31:0] SEED = 32'd18126;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      as_n, uds_n, lds_n, r_w, vpa;
  addr_t     address;
  data_t     cpu_wdata, cpu_rdata;
  logic      dtack_n;
  logic      cpu_halt, halted;
  logic      host_cs, host_we, host_ack;
  byte_sel_t host_bs;
  addr_t     host_adr;
  data_t     host_wdat, host_rdat;
  addr_t     address_out;
  data_t     data_out;
  logic      rd, hwr, lwr;
  data_t     data_in = '0;
  logic      dbr = 1'b0;
  logic      nrdy = 1'b0;

  data_t       chip_mem [256];  // what the chip bus sees
  data_t       exp_mem [256];   // reference model
  logic [31:0] stim_seed = SEED;
  logic [31:0] stall_seed = SEED ^ 32'h0000_5555;
  logic        stall_en = 1'b0;
  int          stall_cnt = 0;
  int          cycles = 0;
  int          tb_phase = 0;
  logic        cck_prev = 1'b0;
  logic        dtack_prev = 1'b1;

  chip_bus_bridge i_chip_bus_bridge (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next(inout logic [31:0] s);
    s = s * 32'd1103515245 + 32'd12345;
    return s;
  endfunction

  function automatic data_t fill_word(int i);
    logic [7:0] b;
    b = 8'(i);
    return {b ^ 8'ha5, ~b};
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // global limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT)
      stop_run("run exceeded its cycle limit");
  end

  // chip memory, stalls and cycle monitors
  always @(negedge clk) begin
    logic [31:0] r;
    if (!rst_n) begin
      for (int i = 0; i < 256; i++)
        chip_mem[i] = fill_word(i);
      tb_phase = 0;
      cck_prev = 1'b0;
      dtack_prev = 1'b1;
    end else begin
      if (i_chip_bus_bridge.cck && !cck_prev)
        tb_phase = (tb_phase == ECLK_PHASES_DEF - 1) ? 0 : tb_phase + 1;
      cck_prev = i_chip_bus_bridge.cck;
      if (dtack_prev && !dtack_n && vpa) begin
        check_bit("vma", i_chip_bus_bridge.vma, 1'b1);
        check_bit("eclk_phase_at_ack", tb_phase == ACK_PHASE, 1'b1);
      end
      dtack_prev = dtack_n;
      if (rd || hwr || lwr) begin
        check_bit("dbr", dbr, 1'b0);
        check_bit("nrdy", nrdy, 1'b0);
      end
      if (halted)
        check_bit("dtack_n", dtack_n, 1'b1);
      if (hwr)
        chip_mem[address_out[8:1]][15:8] = data_out[15:8];
      if (lwr)
        chip_mem[address_out[8:1]][7:0] = data_out[7:0];
      data_in = rd ? chip_mem[address_out[8:1]] : 16'h0000;
      if (stall_cnt > 0) begin
        stall_cnt = stall_cnt - 1;
        if (stall_cnt == 0) begin
          dbr  = 1'b0;
          nrdy = 1'b0;
        end
      end else if (stall_en && (i_chip_bus_bridge.i_ctrl.state == IDLE ||
                                i_chip_bus_bridge.i_ctrl.state == WAIT_SLOT)) begin
        r = lcg_next(stall_seed);
        if (r[31:29] == 3'b000) begin  // new stall of random length
          stall_cnt = 1 + int'(r[20:16]);
          dbr  = r[24];
          nrdy = !r[24] || r[25];
        end
      end
    end
  end

  task automatic wait_dtack(input logic level);
    int n;
    n = 0;
    while (dtack_n !== level) begin
      @(negedge clk);
      n++;
      if (n > ACK_LIMIT)
        stop_run("dtack_n did not respond within 200 cycles");
    end
  endtask

  // one chip bus strobe with its address and write data checked
  task automatic wait_strobe(input addr_t a, input data_t wd);
    int n;
    n = 0;
    while (!(rd || hwr || lwr)) begin
      @(negedge clk);
      n++;
      if (n > ACK_LIMIT)
        stop_run("no chip bus strobe after the acknowledge");
    end
    while (rd || hwr || lwr) begin
      check_addr("address_out", address_out, a);
      if (hwr || lwr)
        check_data("data_out", data_out, wd);
      @(negedge clk);
    end
  endtask

  task automatic merge_write(input addr_t a, input byte_sel_t bs, input data_t wd);
    if (bs[1])
      exp_mem[a[8:1]][15:8] = wd[15:8];
    if (bs[0])
      exp_mem[a[8:1]][7:0] = wd[7:0];
  endtask

  task automatic cpu_cycle(input addr_t a, input logic rw, input byte_sel_t bs,
                           input data_t wd, input logic use_vpa);
    @(negedge clk);
    address   = a;
    r_w       = rw;
    uds_n     = !bs[1];
    lds_n     = !bs[0];
    cpu_wdata = wd;
    vpa       = use_vpa;
    as_n      = 1'b0;
    wait_dtack(1'b0);
    wait_strobe(a, wd);
    as_n  = 1'b1;
    uds_n = 1'b1;
    lds_n = 1'b1;
    if (rw)
      check_data("cpu_rdata", cpu_rdata, exp_mem[a[8:1]]);
    else
      merge_write(a, bs, wd);
    wait_dtack(1'b1);
    vpa = 1'b0;
  endtask

  task automatic host_cycle(input addr_t a, input logic we, input byte_sel_t bs,
                            input data_t wd);
    int n;
    n = 0;
    @(negedge clk);
    host_adr  = a;
    host_we   = we;
    host_bs   = bs;
    host_wdat = wd;
    host_cs   = 1'b1;
    while (host_ack !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > ACK_LIMIT)
        stop_run("host_ack did not arrive within 200 cycles");
    end
    host_cs = 1'b0;
    wait_strobe(a, wd);
    if (we)
      merge_write(a, bs, wd);
    else
      check_data("host_rdat", host_rdat, exp_mem[a[8:1]]);
  endtask

  task automatic set_halt(input logic level);
    int n;
    n = 0;
    @(negedge clk);
    cpu_halt = level;
    while (halted !== level) begin
      @(negedge clk);
      n++;
      if (n > ACK_LIMIT)
        stop_run("halted did not follow cpu_halt");
    end
  endtask

  // 16 shared word slots so that reads hit earlier writes
  task automatic random_cycles(input int count, input logic use_vpa, input logic host);
    logic [31:0] r;
    logic [31:0] d;
    addr_t       a;
    byte_sel_t   bs;
    for (int k = 0; k < count; k++) begin
      r  = lcg_next(stim_seed);
      d  = lcg_next(stim_seed);
      a  = {r[30:16], 4'h0, r[12:9]};
      bs = (r[7:6] == 2'b00) ? 2'b11 : r[7:6];
      if (host)
        host_cycle(a, r[5], bs, d[23:8]);
      else
        cpu_cycle(a, r[5], bs, d[23:8], use_vpa);
    end
  endtask

  initial begin
    logic [31:0] r;
    for (int i = 0; i < 256; i++)
      exp_mem[i] = fill_word(i);
    rst_n     = 1'b0;
    as_n      = 1'b1;
    uds_n     = 1'b1;
    lds_n     = 1'b1;
    r_w       = 1'b1;
    vpa       = 1'b0;
    address   = '0;
    cpu_wdata = '0;
    cpu_halt  = 1'b0;
    host_cs   = 1'b0;
    host_we   = 1'b0;
    host_bs   = '0;
    host_adr  = '0;
    host_wdat = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("dtack_n", dtack_n, 1'b1);
    check_bit("host_ack", host_ack, 1'b0);
    check_bit("rd", rd, 1'b0);
    check_bit("hwr", hwr, 1'b0);
    check_bit("lwr", lwr, 1'b0);
    check_bit("halted", halted, 1'b0);
    check_data("cpu_rdata", cpu_rdata, 16'h0000);

    random_cycles(60, 1'b0, 1'b0);
    stall_en = 1'b1;
    random_cycles(80, 1'b0, 1'b0);

    // vpa cycles ignore dbr, so let running stalls drain first
    stall_en = 1'b0;
    while (stall_cnt != 0)
      @(negedge clk);
    random_cycles(20, 1'b1, 1'b0);

    stall_en = 1'b1;
    set_halt(1'b1);
    random_cycles(40, 1'b0, 1'b1);
    set_halt(1'b0);
    for (int k = 0; k < 16; k++) begin
      r = lcg_next(stim_seed);
      cpu_cycle({r[30:16], 4'h0, 4'(k)}, 1'b1, 2'b11, 16'h0000, 1'b0);
    end
    stall_en = 1'b0;

    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== chip_bus_bridge.f ====
hdl/bus_types_pkg.sv
hdl/chip_timing_pkg.sv
hdl/bus_clock_gen.sv
hdl/bus_master_mux.sv
hdl/read_capture.sv
hdl/bridge_ctrl.sv
hdl/chip_bus_bridge.sv
sim/bridge_assert.sv
sim/tb_chip_bus_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_chip_bus_bridge \
  -f chip_bus_bridge.f \
  -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^Simulation passed$"; then
  exit 0
fi
exit 1
